// ==== files.f ====
+incdir+include
src/usb_tx_pkg.sv
src/usb_tx_bit_timer.sv
src/usb_tx_ctrl.sv
src/usb_tx_serializer.sv
src/usb_tx_nrzi_driver.sv
src/usb_tx_phy.sv
tb/usb_tx_checker.sv
tb/tb_usb_tx.sv

// ==== include/usb_tx_macros.svh ====
// Fixed constants of the USB full-speed transmit PHY.
// Only the bit sample count is meant to be overridden, through the BIT_SAMPLES parameter.
`ifndef USB_TX_MACROS_SVH
`define USB_TX_MACROS_SVH

// Clocks per bit time. The clock must run at 12 MHz times this value.
`define USB_TX_BIT_SAMPLES 4

// SYNC pattern sent LSB first: seven zeros, then a one.
`define USB_TX_SYNC_BYTE 8'h80

// A zero is inserted after this many consecutive ones.
`define USB_TX_STUFF_LIMIT 6

// SE0 bit times at the end of a packet.
`define USB_TX_EOP_SE0_BITS 2

`endif

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_usb_tx -Mdir obj_dir -o tb_usb_tx -f files.f \
   || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/tb_usb_tx)
echo "$sim_out"
echo "$sim_out" | grep -q "TESTBENCH PASSED" && echo "simulation ok" \
   || { echo "simulation did not pass"; exit 1; }

// ==== src/usb_tx_bit_timer.sv ====
// Bit period generator for the transmit PHY.
// BIT_SAMPLES must be 2 or more. The counter stays cleared while run_i is low,
// so the first tick after run_i rises comes BIT_SAMPLES-1 cycles later.
`include "usb_tx_macros.svh"

module usb_tx_bit_timer #(
   parameter int BIT_SAMPLES = `USB_TX_BIT_SAMPLES
) (
   input  logic clk_i,
   input  logic rstn_i,
   input  logic run_i,
   output logic bit_tick_o
);

   localparam int CNT_W = $clog2(BIT_SAMPLES);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BIT_SAMPLES - 1);

   logic [CNT_W-1:0] cnt_q;

   // The tick does not depend on run_i, so the closing tick of a packet
   // still fires in the cycle where the controller drops run.
   assign bit_tick_o = (cnt_q == CNT_LAST);

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         cnt_q <= '0;
      end else if (!run_i || bit_tick_o) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

endmodule

// ==== src/usb_tx_ctrl.sv ====
// Packet sequencer of the transmit PHY.
// Outputs describe the bit launched at the current tick and are only valid then.
// tx_valid_i must be high at the byte boundary and at the tick before it for the
// next byte to be taken, otherwise the packet ends with EOP.
`include "usb_tx_macros.svh"

module usb_tx_ctrl (
   input  logic                  clk_i,
   input  logic                  rstn_i,
   input  logic                  bit_tick_i,
   input  logic                  tx_valid_i,
   input  logic                  stuff_now_i,
   output usb_tx_pkg::shift_op_e shift_op_o,
   output logic                  tx_ready_o,
   output logic                  se0_req_o,
   output logic                  active_o,
   output logic                  run_o
);

   localparam logic [1:0] SE0_BITS = 2'(`USB_TX_EOP_SE0_BITS);
   // Count value at the tick that ends the trailing J bit.
   localparam logic [1:0] EOP_LAST = 2'(`USB_TX_EOP_SE0_BITS + 1);

   usb_tx_pkg::tx_state_e state_q;
   usb_tx_pkg::tx_state_e state_d;
   logic [2:0]            bit_cnt_q;
   logic [2:0]            bit_cnt_d;
   logic [1:0]            eop_cnt_q;
   logic [1:0]            eop_cnt_d;
   logic                  valid_q;
   logic                  load_ok;
   logic                  ready;

   assign load_ok    = tx_valid_i & valid_q;
   assign tx_ready_o = ready & bit_tick_i;
   assign run_o      = (state_q != usb_tx_pkg::ST_IDLE) | tx_valid_i;

   always_comb begin
      state_d    = state_q;
      bit_cnt_d  = bit_cnt_q;
      eop_cnt_d  = eop_cnt_q;
      shift_op_o = usb_tx_pkg::SH_HOLD;
      ready      = 1'b0;
      active_o   = 1'b1;
      se0_req_o  = 1'b0;
      case (state_q)
         usb_tx_pkg::ST_IDLE: begin
            active_o = 1'b0;
            // Preload SYNC so that its first bit goes out on the next tick.
            if (tx_valid_i) begin
               shift_op_o = usb_tx_pkg::SH_LOAD_SYNC;
               state_d    = usb_tx_pkg::ST_SYNC;
               bit_cnt_d  = 3'd0;
            end
         end
         usb_tx_pkg::ST_SYNC, usb_tx_pkg::ST_DATA: begin
            // A stuff bit freezes the bit counter while the serializer forces the zero.
            if (!stuff_now_i) begin
               if (bit_cnt_q == 3'd7) begin
                  bit_cnt_d = 3'd0;
                  if (load_ok) begin
                     shift_op_o = usb_tx_pkg::SH_LOAD_DATA;
                     ready      = 1'b1;
                     state_d    = usb_tx_pkg::ST_DATA;
                  end else begin
                     shift_op_o = usb_tx_pkg::SH_SHIFT;
                     state_d    = usb_tx_pkg::ST_EOP;
                     eop_cnt_d  = 2'd0;
                  end
               end else begin
                  shift_op_o = usb_tx_pkg::SH_SHIFT;
                  bit_cnt_d  = bit_cnt_q + 3'd1;
               end
            end
         end
         usb_tx_pkg::ST_EOP: begin
            // A pending stuff bit after the last byte goes out before SE0.
            if (!stuff_now_i) begin
               se0_req_o = (eop_cnt_q < SE0_BITS);
               if (eop_cnt_q == EOP_LAST) begin
                  active_o = 1'b0;
                  state_d  = usb_tx_pkg::ST_IDLE;
               end else begin
                  eop_cnt_d = eop_cnt_q + 2'd1;
               end
            end
         end
         default: begin
            state_d = usb_tx_pkg::ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         state_q   <= usb_tx_pkg::ST_IDLE;
         bit_cnt_q <= 3'd0;
         eop_cnt_q <= 2'd0;
         valid_q   <= 1'b0;
      end else if (bit_tick_i) begin
         state_q   <= state_d;
         bit_cnt_q <= bit_cnt_d;
         eop_cnt_q <= eop_cnt_d;
         valid_q   <= tx_valid_i;
      end
   end

endmodule

// ==== src/usb_tx_nrzi_driver.sv ====
// NRZI encoder and line driver of the transmit PHY.
// All outputs come straight from registers updated on the bit tick, so dp, dn
// and the enable switch in the same clock edge. Idle line is J.

module usb_tx_nrzi_driver (
   input  logic clk_i,
   input  logic rstn_i,
   input  logic bit_tick_i,
   input  logic line_bit_i,
   input  logic se0_req_i,
   input  logic active_i,
   output logic tx_en_o,
   output logic dp_tx_o,
   output logic dn_tx_o
);

   logic nrzi_q;
   logic se0_q;
   logic en_q;

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         nrzi_q <= 1'b1;
         se0_q  <= 1'b0;
         en_q   <= 1'b0;
      end else if (bit_tick_i) begin
         en_q  <= active_i;
         se0_q <= active_i & se0_req_i;
         // Back to J when idle, during SE0 and for the bit that follows it.
         if (!active_i || se0_req_i || se0_q) begin
            nrzi_q <= 1'b1;
         end else if (!line_bit_i) begin
            nrzi_q <= ~nrzi_q;
         end
      end
   end

   assign tx_en_o = en_q;
   assign dp_tx_o = nrzi_q & ~se0_q;
   assign dn_tx_o = ~nrzi_q & ~se0_q;

endmodule

// ==== src/usb_tx_phy.sv ====
// USB 2.0 full-speed transmit PHY with SYNC, LSB-first serialization, bit stuffing,
// NRZI and EOP. Clock must be 12 MHz times BIT_SAMPLES, with BIT_SAMPLES >= 2.
// tx_data_i is taken in the single cycle where tx_ready_o is high.
// No CRC, low-speed, resume or bus reset signaling.
`include "usb_tx_macros.svh"

module usb_tx_phy #(
   parameter int BIT_SAMPLES = `USB_TX_BIT_SAMPLES
) (
   input  logic       clk_i,
   input  logic       rstn_i,
   input  logic       tx_valid_i,
   input  logic [7:0] tx_data_i,
   output logic       tx_ready_o,
   output logic       tx_en_o,
   output logic       dp_tx_o,
   output logic       dn_tx_o
);

   usb_tx_pkg::shift_op_e shift_op;
   logic                  bit_tick;
   logic                  run;
   logic                  stuff_now;
   logic                  line_bit;
   logic                  se0_req;
   logic                  active;

   usb_tx_bit_timer #(
      .BIT_SAMPLES(BIT_SAMPLES)
   ) i_bit_timer (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .run_i      (run),
      .bit_tick_o (bit_tick)
   );

   usb_tx_ctrl i_ctrl (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .bit_tick_i  (bit_tick),
      .tx_valid_i  (tx_valid_i),
      .stuff_now_i (stuff_now),
      .shift_op_o  (shift_op),
      .tx_ready_o  (tx_ready_o),
      .se0_req_o   (se0_req),
      .active_o    (active),
      .run_o       (run)
   );

   // The SE0 bits of every EOP clear the ones count, so each packet starts at zero.
   usb_tx_serializer i_serializer (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .bit_tick_i  (bit_tick),
      .shift_op_i  (shift_op),
      .data_i      (tx_data_i),
      .clr_stuff_i (se0_req),
      .line_bit_o  (line_bit),
      .stuff_now_o (stuff_now)
   );

   usb_tx_nrzi_driver i_nrzi_driver (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .bit_tick_i (bit_tick),
      .line_bit_i (line_bit),
      .se0_req_i  (se0_req),
      .active_i   (active),
      .tx_en_o    (tx_en_o),
      .dp_tx_o    (dp_tx_o),
      .dn_tx_o    (dn_tx_o)
   );

endmodule

// ==== src/usb_tx_pkg.sv ====
// Types shared by the USB full-speed transmit PHY.
// Both enums are two bits wide and use every code.
package usb_tx_pkg;

   // Packet phase of the transmit controller.
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_SYNC = 2'd1,
      ST_DATA = 2'd2,
      ST_EOP  = 2'd3
   } tx_state_e;

   // Serializer opcode, acted on only in bit tick cycles.
   typedef enum logic [1:0] {
      SH_HOLD      = 2'd0,
      SH_SHIFT     = 2'd1,
      SH_LOAD_SYNC = 2'd2,
      SH_LOAD_DATA = 2'd3
   } shift_op_e;

endpackage

// ==== src/usb_tx_serializer.sv ====
// Byte serializer with bit stuffing for the transmit PHY.
// Bits leave LSB first. The ones counter runs across byte boundaries and is
// cleared by clr_stuff_i or by sending a stuffed zero.
`include "usb_tx_macros.svh"

module usb_tx_serializer (
   input  logic                  clk_i,
   input  logic                  rstn_i,
   input  logic                  bit_tick_i,
   input  usb_tx_pkg::shift_op_e shift_op_i,
   input  logic [7:0]            data_i,
   input  logic                  clr_stuff_i,
   output logic                  line_bit_o,
   output logic                  stuff_now_o
);

   localparam logic [2:0] STUFF_LIMIT = 3'(`USB_TX_STUFF_LIMIT);

   logic [7:0] shreg_q;
   logic [2:0] ones_q;
   logic       sends_bit;

   // Only a shift or a data load launches the current LSB.
   assign sends_bit = (shift_op_i == usb_tx_pkg::SH_SHIFT) ||
                      (shift_op_i == usb_tx_pkg::SH_LOAD_DATA);

   assign stuff_now_o = (ones_q == STUFF_LIMIT);
   assign line_bit_o  = stuff_now_o ? 1'b0 : shreg_q[0];

   // Register contents are held through a stuff bit whatever the opcode.
   always_ff @(posedge clk_i) begin
      if (bit_tick_i && !stuff_now_o) begin
         case (shift_op_i)
            usb_tx_pkg::SH_SHIFT:     shreg_q <= {1'b0, shreg_q[7:1]};
            usb_tx_pkg::SH_LOAD_SYNC: shreg_q <= `USB_TX_SYNC_BYTE;
            usb_tx_pkg::SH_LOAD_DATA: shreg_q <= data_i;
            default:                  shreg_q <= shreg_q;
         endcase
      end
   end

   // Run length of ones sent on the line.
   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         ones_q <= 3'd0;
      end else if (bit_tick_i) begin
         if (stuff_now_o || clr_stuff_i) begin
            ones_q <= 3'd0;
         end else if (sends_bit) begin
            if (shreg_q[0]) begin
               ones_q <= ones_q + 3'd1;
            end else begin
               ones_q <= 3'd0;
            end
         end
      end
   end

endmodule

// ==== tb/tb_usb_tx.sv ====
// Testbench for the USB full-speed transmit PHY.
// Packets of up to eight bytes go through the valid/ready handshake.
// Line checks are done in usb_tx_checker.
`include "usb_tx_macros.svh"

module tb_usb_tx;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int BIT_SAMPLES = `USB_TX_BIT_SAMPLES;
   // Several byte times at the bit rate.
   localparam int TIMEOUT_CYC = 40 * BIT_SAMPLES;

   logic       clk_i;
   logic       rstn_i;
   logic       tx_valid_i;
   logic [7:0] tx_data_i;
   logic       tx_ready_o;
   logic       tx_en_o;
   logic       dp_tx_o;
   logic       dn_tx_o;
   integer     seed;
   int         tb_err;
   int         pkts_sent;
   int         bytes_sent;
   bit         timed_out;
   int         chk_err;
   int         chk_pkts;
   int         chk_bytes;

   always #2 clk_i = ~clk_i;

   usb_tx_phy #(
      .BIT_SAMPLES(BIT_SAMPLES)
   ) i_usb_tx_phy (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .tx_valid_i (tx_valid_i),
      .tx_data_i  (tx_data_i),
      .tx_ready_o (tx_ready_o),
      .tx_en_o    (tx_en_o),
      .dp_tx_o    (dp_tx_o),
      .dn_tx_o    (dn_tx_o)
   );

   usb_tx_checker #(
      .BIT_SAMPLES(BIT_SAMPLES)
   ) i_checker (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .valid_i    (tx_valid_i),
      .data_i     (tx_data_i),
      .ready_i    (tx_ready_o),
      .en_i       (tx_en_o),
      .dp_i       (dp_tx_o),
      .dn_i       (dn_tx_o),
      .err_cnt_o  (chk_err),
      .pkt_cnt_o  (chk_pkts),
      .byte_cnt_o (chk_bytes)
   );

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk_i);
   endtask

   // Ready is a one-cycle pulse, so it is looked for at falling edges.
   task automatic wait_ready(output bit ok);
      int cyc;
      ok  = 1'b0;
      cyc = 0;
      while (!ok && cyc < TIMEOUT_CYC) begin
         @(negedge clk_i);
         ok = tx_ready_o;
         cyc++;
      end
      if (!ok) $display("time %0t: timeout, tx_ready_o never pulsed for the next byte", $time);
   endtask

   task automatic wait_line_idle(output bit ok);
      int cyc;
      ok  = 1'b0;
      cyc = 0;
      while (!ok && cyc < TIMEOUT_CYC) begin
         @(negedge clk_i);
         ok = !tx_en_o;
         cyc++;
      end
      if (!ok) $display("time %0t: timeout, tx_en_o stayed high after the packet", $time);
   endtask

   // Byte 0 of the packet sits in the low bits of data.
   task automatic send_packet(input logic [63:0] data, input int len);
      bit ok;
      int i;
      if (!timed_out) begin
         @(posedge clk_i);
         tx_valid_i <= 1'b1;
         tx_data_i  <= data[7:0];
         ok = 1'b1;
         i  = 0;
         while (ok && i < len) begin
            wait_ready(ok);
            if (ok) begin
               // This edge takes the byte, so the next one is put up now.
               @(posedge clk_i);
               if (i == len - 1) begin
                  tx_valid_i <= 1'b0;
               end else begin
                  tx_data_i <= data[8*(i+1) +: 8];
               end
            end
            i++;
         end
         if (ok) wait_line_idle(ok);
         if (!ok) begin
            @(posedge clk_i);
            tx_valid_i <= 1'b0;
            timed_out = 1'b1;
            tb_err++;
         end else begin
            pkts_sent++;
            bytes_sent += len;
         end
      end
   endtask

   initial begin
      logic [63:0] data;
      int          len;
      clk_i      = 1'b0;
      rstn_i     = 1'b0;
      tx_valid_i = 1'b0;
      tx_data_i  = 8'h00;
      seed       = 95202;
      repeat (3) @(posedge clk_i);
      rstn_i <= 1'b1;
      // Idle line after reset.
      idle_cycles(20 * BIT_SAMPLES);
      send_packet(64'hA5, 1);
      send_packet(64'h89_67_45_23_01, 5);
      // Stuffing inside a byte, across byte boundaries and right after SYNC.
      send_packet(64'hFF, 1);
      send_packet(64'hFF_FF_FF, 3);
      send_packet(64'h7E_0F_F0, 3);
      send_packet(64'h01_FE_7F_3F, 4);
      for (int p = 0; p < 20; p++) begin
         len  = 1 + ($unsigned($random(seed)) % 8);
         data = {$random(seed), $random(seed)};
         send_packet(data, len);
         idle_cycles($unsigned($random(seed)) % 16);
      end
      idle_cycles(4 * BIT_SAMPLES);
      if (chk_pkts != pkts_sent || chk_bytes != bytes_sent) begin
         $display("mismatch time %0t: checker saw %0d packets, %0d bytes, expected %0d, %0d",
                  $time, chk_pkts, chk_bytes, pkts_sent, bytes_sent);
         tb_err++;
      end
      $display("%0d packets checked, %0d checker errors, %0d testbench errors",
               chk_pkts, chk_err, tb_err);
      if (chk_err == 0 && tb_err == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== tb/usb_tx_checker.sv ====
// Line monitor for the USB transmit PHY testbench.
// Samples dp and dn in the middle of each bit while tx_en is high and compares
// each packet with a reference stream built from the bytes taken at ready pulses.
`include "usb_tx_macros.svh"

module usb_tx_checker #(
   parameter int BIT_SAMPLES = `USB_TX_BIT_SAMPLES
) (
   input  logic       clk_i,
   input  logic       rstn_i,
   input  logic       valid_i,
   input  logic [7:0] data_i,
   input  logic       ready_i,
   input  logic       en_i,
   input  logic       dp_i,
   input  logic       dn_i,
   output int         err_cnt_o,
   output int         pkt_cnt_o,
   output int         byte_cnt_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // Line state code is {dn, dp}.
   localparam logic [1:0] LN_SE0 = 2'd0;
   localparam logic [1:0] LN_J   = 2'd1;
   localparam logic [1:0] LN_K   = 2'd2;

   logic [7:0] byte_q[$];
   logic [1:0] line_q[$];
   logic [1:0] exp_q[$];
   int         phase;
   logic       en_prev;
   logic       ready_prev;

   function automatic string line_name(input logic [1:0] code);
      string names[4] = '{"SE0", "J", "K", "SE1"};
      return names[code];
   endfunction

   // Builds the expected line from SYNC and the bytes LSB first, with a zero
   // after six ones, NRZI from J and the EOP.
   function automatic void build_expected();
      logic [7:0] cur;
      logic       level;
      int         ones;
      exp_q.delete();
      level = 1'b1;
      ones  = 0;
      for (int b = 0; b <= byte_q.size(); b++) begin
         if (b == 0) begin
            cur = `USB_TX_SYNC_BYTE;
         end else begin
            cur = byte_q[b-1];
         end
         for (int k = 0; k < 8; k++) begin
            if (cur[k]) begin
               ones++;
            end else begin
               level = ~level;
               ones  = 0;
            end
            exp_q.push_back(level ? LN_J : LN_K);
            if (ones == `USB_TX_STUFF_LIMIT) begin
               level = ~level;
               ones  = 0;
               exp_q.push_back(level ? LN_J : LN_K);
            end
         end
      end
      repeat (`USB_TX_EOP_SE0_BITS) exp_q.push_back(LN_SE0);
      exp_q.push_back(LN_J);
   endfunction

   function automatic void check_packet();
      int n;
      bit diff;
      build_expected();
      if (byte_q.size() == 0) begin
         $display("packet %0d went out on the line without any byte handshake", pkt_cnt_o);
         err_cnt_o++;
      end
      if (line_q.size() != exp_q.size()) begin
         $display("mismatch time %0t: packet %0d lasted %0d bit times, expected %0d",
                  $time, pkt_cnt_o, line_q.size(), exp_q.size());
         err_cnt_o++;
      end
      n    = (line_q.size() < exp_q.size()) ? line_q.size() : exp_q.size();
      diff = 1'b0;
      for (int i = 0; i < n && !diff; i++) begin
         if (line_q[i] != exp_q[i]) begin
            $display("mismatch time %0t: packet %0d bit %0d is %s, expected %s", $time,
                     pkt_cnt_o, i, line_name(line_q[i]), line_name(exp_q[i]));
            err_cnt_o++;
            diff = 1'b1;
         end
      end
      pkt_cnt_o++;
      byte_q.delete();
      line_q.delete();
   endfunction

   always @(negedge clk_i) begin
      if (!rstn_i) begin
         phase   = 0;
         en_prev = 1'b0;
         ready_prev = 1'b0;
         byte_q.delete();
         line_q.delete();
      end else begin
         if (ready_i) begin
            if (ready_prev || !valid_i || !en_i) begin
               $display("mismatch time %0t: tx_ready_o pulse longer than one cycle, %s",
                        $time, "outside a packet or without tx_valid_i");
               err_cnt_o++;
            end
            byte_q.push_back(data_i);
            byte_cnt_o++;
         end
         if (en_i) begin
            if (!en_prev || phase == BIT_SAMPLES - 1) begin
               phase = 0;
            end else begin
               phase++;
            end
            if (phase == BIT_SAMPLES / 2) begin
               line_q.push_back({dn_i, dp_i});
            end
         end else if (en_prev) begin
            check_packet();
         end else if ({dn_i, dp_i} != LN_J) begin
            $display("mismatch time %0t: idle line is %s, expected J", $time,
                     line_name({dn_i, dp_i}));
            err_cnt_o++;
         end
         en_prev    = en_i;
         ready_prev = ready_i;
      end
   end

endmodule
